/* compile.f */
rtl/cce_cache_pkg.sv
rtl/store_data_align.sv
rtl/cmd_opcode_decode.sv
rtl/cache_bridge_ctrl.sv
rtl/resp_header_fifo.sv
rtl/load_data_pack.sv
rtl/cce_to_cache.sv
testbench/tb_clock.sv
testbench/cce_to_cache_props.sv
testbench/tb_cce_to_cache.sv

/* Makefile */
SIM := obj_dir/Vtb_cce_to_cache

all: run

$(SIM): compile.f $(shell cat compile.f)
	verilator --binary --timing --assert --top-module tb_cce_to_cache -f compile.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* testbench/tb_cce_to_cache.sv */
// random commands against a byte-addressed cache model of 256 words
// stores and atomics both act as masked writes in the cache model and return the old word
`timescale 1ns/100ps

module tb_cce_to_cache;

  localparam int sets_c        = 16;
  localparam int assoc_c       = 2;
  localparam int outstanding_c = 2;
  localparam int lines_c       = sets_c * assoc_c;
  localparam int lg_lines_c    = $clog2(lines_c);
  localparam int cmds_c        = 300;
  localparam int drive_delay_c = 10;
  // clear allowance covers reset plus a few cycles per tag store
  localparam int timeout_c     = cmds_c * 20 + lines_c * 8 + 16;

  logic                       clk_i;
  logic                       reset_i;
  cce_cache_pkg::mem_header_s cmd_header_i;
  cce_cache_pkg::data_t       cmd_data_i;
  logic                       cmd_v_i;
  logic                       cmd_ready_o;
  cce_cache_pkg::cache_pkt_s  cache_pkt_o;
  logic                       cache_pkt_v_o;
  logic                       cache_pkt_ready_i;
  cce_cache_pkg::data_t       cache_data_i;
  logic                       cache_data_v_i;
  logic                       cache_data_yumi_o;
  cce_cache_pkg::mem_header_s resp_header_o;
  cce_cache_pkg::data_t       resp_data_o;
  logic                       resp_v_o;
  logic                       resp_ready_i;

  cce_cache_pkg::data_t       mem [256];
  cce_cache_pkg::data_t       ret_q [$];
  cce_cache_pkg::mem_header_s exp_hdr_q [$];
  cce_cache_pkg::data_t       exp_data_q [$];
  logic [31:0]                rng_state = 32'hb654;
  int ret_delay       = 0;
  int stall_left      = 0;
  int issued          = 0;
  int accepted        = 0;
  int responses       = 0;
  int tag_sent        = 0;
  int tag_acked       = 0;
  int value_errors    = 0;
  int protocol_errors = 0;
  int cycle_count     = 0;
  logic clear_done    = 1'b0;
  logic cmd_taken     = 1'b0;

  tb_clock clock_i (.clk_o(clk_i));

  cce_to_cache #(
    .sets_p        (sets_c),
    .assoc_p       (assoc_c),
    .outstanding_p (outstanding_c)
  ) dut_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .cmd_header_i      (cmd_header_i),
    .cmd_data_i        (cmd_data_i),
    .cmd_v_i           (cmd_v_i),
    .cmd_ready_o       (cmd_ready_o),
    .cache_pkt_o       (cache_pkt_o),
    .cache_pkt_v_o     (cache_pkt_v_o),
    .cache_pkt_ready_i (cache_pkt_ready_i),
    .cache_data_i      (cache_data_i),
    .cache_data_v_i    (cache_data_v_i),
    .cache_data_yumi_o (cache_data_yumi_o),
    .resp_header_o     (resp_header_o),
    .resp_data_o       (resp_data_o),
    .resp_v_o          (resp_v_o),
    .resp_ready_i      (resp_ready_i)
  );

  bind cce_to_cache cce_to_cache_props props_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_ready_i (cmd_ready_o),
    .pkt_v_i     (cache_pkt_v_o),
    .pkt_ready_i (cache_pkt_ready_i),
    .data_v_i    (cache_data_v_i),
    .data_yumi_i (cache_data_yumi_o),
    .resp_v_i    (resp_v_o)
  );

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output logic [31:0] r);
    rng_state = xorshift(rng_state);
    r = rng_state;
  endtask

  // low 2^size bytes copied into every slot of the word
  function automatic cce_cache_pkg::data_t replicate(cce_cache_pkg::data_t d,
                                                     cce_cache_pkg::msg_size_e s);
    cce_cache_pkg::data_t r;
    int n;
    n = 1 << int'(s);
    for (int i = 0; i < 8; i++)
      r[8*i +: 8] = d[8*(i % n) +: 8];
    return r;
  endfunction

  function automatic cce_cache_pkg::cache_opcode_e expect_opcode(cce_cache_pkg::mem_header_s h);
    logic [5:0] w_op;
    logic [5:0] d_op;
    if (h.msg_type == cce_cache_pkg::msg_rd || h.msg_type == cce_cache_pkg::msg_uc_rd)
    begin
      if (h.size == cce_cache_pkg::size_1)
        return cce_cache_pkg::op_lb;
      if (h.size == cce_cache_pkg::size_2)
        return cce_cache_pkg::op_lh;
      return (h.size == cce_cache_pkg::size_4) ? cce_cache_pkg::op_lw : cce_cache_pkg::op_ld;
    end
    if (!(h.msg_type inside {cce_cache_pkg::msg_wr, cce_cache_pkg::msg_uc_wr,
                             cce_cache_pkg::msg_amo}))
      return cce_cache_pkg::op_lb;
    if (h.size == cce_cache_pkg::size_1)
      return cce_cache_pkg::op_sb;
    if (h.size == cce_cache_pkg::size_2)
      return cce_cache_pkg::op_sh;
    case (h.subop)
      cce_cache_pkg::subop_store: {w_op, d_op} = {cce_cache_pkg::op_sw, cce_cache_pkg::op_sd};
      cce_cache_pkg::subop_swap:
        {w_op, d_op} = {cce_cache_pkg::op_amoswap_w, cce_cache_pkg::op_amoswap_d};
      cce_cache_pkg::subop_add:
        {w_op, d_op} = {cce_cache_pkg::op_amoadd_w, cce_cache_pkg::op_amoadd_d};
      cce_cache_pkg::subop_xor:
        {w_op, d_op} = {cce_cache_pkg::op_amoxor_w, cce_cache_pkg::op_amoxor_d};
      cce_cache_pkg::subop_and:
        {w_op, d_op} = {cce_cache_pkg::op_amoand_w, cce_cache_pkg::op_amoand_d};
      cce_cache_pkg::subop_or:
        {w_op, d_op} = {cce_cache_pkg::op_amoor_w, cce_cache_pkg::op_amoor_d};
      cce_cache_pkg::subop_min:
        {w_op, d_op} = {cce_cache_pkg::op_amomin_w, cce_cache_pkg::op_amomin_d};
      cce_cache_pkg::subop_max:
        {w_op, d_op} = {cce_cache_pkg::op_amomax_w, cce_cache_pkg::op_amomax_d};
      cce_cache_pkg::subop_minu:
        {w_op, d_op} = {cce_cache_pkg::op_amominu_w, cce_cache_pkg::op_amominu_d};
      cce_cache_pkg::subop_maxu:
        {w_op, d_op} = {cce_cache_pkg::op_amomaxu_w, cce_cache_pkg::op_amomaxu_d};
      // lr, sc and anything unknown
      default:
        return cce_cache_pkg::op_lb;
    endcase
    return cce_cache_pkg::cache_opcode_e'((h.size == cce_cache_pkg::size_4) ? w_op : d_op);
  endfunction

  function automatic cce_cache_pkg::cache_pkt_s expect_pkt(cce_cache_pkg::mem_header_s h,
                                                           cce_cache_pkg::data_t d);
    cce_cache_pkg::cache_pkt_s p;
    int n;
    n = 1 << int'(h.size);
    p.opcode = expect_opcode(h);
    p.addr   = h.addr;
    p.data   = replicate(d, h.size);
    for (int i = 0; i < 8; i++)
      p.mask[i] = ((i / n) == (int'(h.addr[2:0]) / n));
    if (h.addr == cce_cache_pkg::tagfl_addr_c)
    begin
      p.opcode = cce_cache_pkg::op_tagfl;
      p.addr   = cce_cache_pkg::paddr_t'(d[lg_lines_c-1:0]) << cce_cache_pkg::block_offset_c;
      p.data   = '0;
      p.mask   = '0;
    end
    return p;
  endfunction

  task automatic check_pkt(cce_cache_pkg::cache_pkt_s got, cce_cache_pkg::cache_pkt_s exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("Error at %0t: cache packet op %h addr %h data %h mask %h", $time,
               got.opcode, got.addr, got.data, got.mask);
      $display("  expected op %h addr %h data %h mask %h",
               exp.opcode, exp.addr, exp.data, exp.mask);
    end
  endtask

  task automatic check_header(cce_cache_pkg::mem_header_s got, cce_cache_pkg::mem_header_s exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("Error at %0t: response header %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_data(cce_cache_pkg::data_t got, cce_cache_pkg::data_t exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("Error at %0t: response data %h, expected %h", $time, got, exp);
    end
  endtask

  // cache model, returns the addressed bytes at the low end of the word
  task automatic cache_access(input cce_cache_pkg::cache_pkt_s p,
                              output cce_cache_pkg::data_t word);
    int idx;
    int off;
    idx  = int'(p.addr[10:3]);
    off  = int'(p.addr[2:0]);
    word = mem[idx] >> (8 * off);
    case (p.opcode)
      cce_cache_pkg::op_tagst, cce_cache_pkg::op_tagfl:
        word = '0;
      cce_cache_pkg::op_lb, cce_cache_pkg::op_lh, cce_cache_pkg::op_lw, cce_cache_pkg::op_ld:
        ;
      default:
        for (int i = 0; i < 8; i++)
          if (p.mask[i])
            mem[idx][8*i +: 8] = p.data[8*i +: 8];
    endcase
  endtask

  task automatic push_return(cce_cache_pkg::data_t w);
    logic [31:0] r;
    if (ret_q.size() == 0)
    begin
      draw(r);
      ret_delay = int'(r % 4);
    end
    ret_q.push_back(w);
  endtask

  task automatic protocol_error(string what);
    protocol_errors++;
    $display("At %0t the bridge %s", $time, what);
  endtask

  task automatic new_command();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    int nbytes;
    draw(r0);
    draw(r1);
    draw(r2);
    draw(r3);
    cmd_header_i.msg_type = cce_cache_pkg::msg_type_e'(3'(r0 % 5));
    cmd_header_i.subop    = cce_cache_pkg::subop_e'(4'(r0[15:8] % 12));
    cmd_header_i.size     = cce_cache_pkg::msg_size_e'({1'b0, r0[17:16]});
    nbytes = 1 << int'(r0[17:16]);
    // a small window keeps loads landing on earlier stores
    if (r0[23:20] == 4'h0)
      cmd_header_i.addr = cce_cache_pkg::tagfl_addr_c;
    else
      cmd_header_i.addr = cce_cache_pkg::dram_base_c | (r1 & 32'h7ff & ~32'(nbytes - 1));
    cmd_data_i = {r2, r3};
    cmd_v_i    = 1'b1;
    issued++;
  endtask

  // sampled mid-cycle, describes what the next rising edge will do
  task automatic observe();
    cce_cache_pkg::cache_pkt_s exp;
    cce_cache_pkg::data_t      word;
    logic [31:0]               r;
    if (cmd_ready_o && !clear_done)
    begin
      clear_done = 1'b1;
      if (tag_sent != lines_c || tag_acked != lines_c)
        protocol_error("opened the command side before every tag store was acknowledged");
    end
    if (resp_v_o && !clear_done)
      protocol_error("raised a response during the tag clear");
    if (cmd_v_i && cmd_ready_o)
    begin
      if (!cache_pkt_v_o)
        protocol_error("took a command without a valid cache packet");
      exp = expect_pkt(cmd_header_i, cmd_data_i);
      check_pkt(cache_pkt_o, exp);
      cache_access(exp, word);
      push_return(word);
      exp_hdr_q.push_back(cmd_header_i);
      exp_data_q.push_back(replicate(word, cmd_header_i.size));
      accepted++;
      cmd_taken = 1'b1;
    end
    else if (cache_pkt_v_o && cache_pkt_ready_i)
    begin
      if (clear_done || tag_sent >= lines_c)
        protocol_error("sent a cache packet that no command asked for");
      exp.opcode = cce_cache_pkg::op_tagst;
      exp.addr   = cce_cache_pkg::paddr_t'(tag_sent) << cce_cache_pkg::block_offset_c;
      exp.data   = '0;
      exp.mask   = '0;
      check_pkt(cache_pkt_o, exp);
      tag_sent++;
      push_return('0);
    end
    if (resp_v_o && resp_ready_i)
    begin
      if (exp_hdr_q.size() == 0)
        protocol_error("returned a response with no command outstanding");
      else
      begin
        check_header(resp_header_o, exp_hdr_q.pop_front());
        check_data(resp_data_o, exp_data_q.pop_front());
        responses++;
      end
      if (!cache_data_yumi_o)
        protocol_error("returned a response without consuming the cache data");
    end
    if (cache_data_yumi_o)
    begin
      if (ret_q.size() == 0)
        protocol_error("consumed cache data that was never returned");
      else
      begin
        void'(ret_q.pop_front());
        draw(r);
        ret_delay = int'(r % 4);
      end
      if (tag_acked < lines_c)
        tag_acked++;
    end
    if (accepted - responses > outstanding_c)
      protocol_error("let more commands be in flight than the FIFO holds");
  endtask

  task automatic drive();
    logic [31:0] r;
    draw(r);
    if (cmd_taken)
    begin
      cmd_v_i   = 1'b0;
      cmd_taken = 1'b0;
    end
    if (!cmd_v_i && issued < cmds_c && r[8:7] != 2'b00)
      new_command();
    cache_pkt_ready_i = (r[1:0] != 2'b00);
    // response back-pressure comes in stretches of up to 8 cycles
    if (stall_left == 0)
    begin
      resp_ready_i = r[2];
      stall_left   = int'(r[5:3]);
    end
    else
      stall_left--;
    cache_data_v_i = (ret_q.size() != 0) && (ret_delay == 0);
    cache_data_i   = (ret_q.size() != 0) ? ret_q[0] : '0;
    // delay of n holds the head word back for n extra cycles
    if (ret_delay > 0)
      ret_delay--;
  endtask

  task automatic print_counts();
    $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
  endtask

  always @(posedge clk_i)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_c)
    begin
      $display("The run timed out after %0d cycles with %0d of %0d responses",
               cycle_count, responses, cmds_c);
      print_counts();
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial
  begin
    reset_i           = 1'b1;
    cmd_header_i      = '0;
    cmd_data_i        = '0;
    cmd_v_i           = 1'b0;
    cache_pkt_ready_i = 1'b0;
    cache_data_i      = '0;
    cache_data_v_i    = 1'b0;
    resp_ready_i      = 1'b0;
    for (int i = 0; i < 256; i++)
      mem[i] = {32'(i) * 32'h9e37_79b9, ~32'(i)};
    repeat (16) @(posedge clk_i);
    #(drive_delay_c);
    reset_i = 1'b0;
    drive();
    while (responses < cmds_c)
    begin
      @(negedge clk_i);
      observe();
      @(posedge clk_i);
      #(drive_delay_c);
      drive();
    end
    if (tag_sent != lines_c || tag_acked != lines_c)
      protocol_error("did not complete exactly one tag store per cache line");
    if (ret_q.size() != 0)
      protocol_error("left cache data unconsumed at the end of the run");
    print_counts();
    if (value_errors == 0 && protocol_errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

/* testbench/cce_to_cache_props.sv */
// handshake and reset rules of the bridge, sampled on the rising clock edge
`timescale 1ns/100ps

module cce_to_cache_props (
  input logic clk_i,
  input logic reset_i,
  input logic cmd_ready_i,
  input logic pkt_v_i,
  input logic pkt_ready_i,
  input logic data_v_i,
  input logic data_yumi_i,
  input logic resp_v_i
);

  no_pkt_in_reset: assert property (@(posedge clk_i) reset_i |-> !pkt_v_i)
    else $error("cache packet valid while reset is asserted");

  // command can only be taken when the cache takes the packet too
  ready_needs_cache: assert property (@(posedge clk_i) cmd_ready_i |-> pkt_ready_i)
    else $error("cmd_ready_o high while cache_pkt_ready_i is low");

  yumi_needs_data: assert property (@(posedge clk_i) data_yumi_i |-> data_v_i)
    else $error("cache data consumed while not valid");

  resp_needs_data: assert property (@(posedge clk_i) resp_v_i |-> data_v_i)
    else $error("response valid without valid cache data");

endmodule

/* testbench/tb_clock.sv */
// free-running testbench clock, starts low
`timescale 1ns/100ps

module tb_clock #(
  parameter int period_p = 100
) (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

endmodule

/* rtl/cce_to_cache.sv */
// bridge from a single-beat memory command channel to one blocking cache bank
// commands carry at most 8 bytes; responses return in command order
`timescale 1ns/100ps

module cce_to_cache #(
  parameter int sets_p        = 16,
  parameter int assoc_p       = 2,
  parameter int outstanding_p = 2
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  cce_cache_pkg::mem_header_s cmd_header_i,
  input  cce_cache_pkg::data_t      cmd_data_i,
  input  logic                      cmd_v_i,
  output logic                      cmd_ready_o,
  output cce_cache_pkg::cache_pkt_s cache_pkt_o,
  output logic                      cache_pkt_v_o,
  input  logic                      cache_pkt_ready_i,
  input  cce_cache_pkg::data_t      cache_data_i,
  input  logic                      cache_data_v_i,
  output logic                      cache_data_yumi_o,
  output cce_cache_pkg::mem_header_s resp_header_o,
  output cce_cache_pkg::data_t      resp_data_o,
  output logic                      resp_v_o,
  input  logic                      resp_ready_i
);

  cce_cache_pkg::cache_pkt_s cmd_pkt;
  cce_cache_pkg::data_t      store_data;
  cce_cache_pkg::mask_t      store_mask;
  logic                      fifo_full;
  logic                      fifo_empty;
  logic                      fifo_push;
  logic                      fifo_pop;

  store_data_align align_i (
    .size_i (cmd_header_i.size),
    .addr_i (cmd_header_i.addr),
    .data_i (cmd_data_i),
    .data_o (store_data),
    .mask_o (store_mask)
  );

  cmd_opcode_decode #(
    .sets_p  (sets_p),
    .assoc_p (assoc_p)
  ) decode_i (
    .cmd_header_i (cmd_header_i),
    .cmd_data_i   (cmd_data_i),
    .store_data_i (store_data),
    .store_mask_i (store_mask),
    .cmd_pkt_o    (cmd_pkt)
  );

  cache_bridge_ctrl #(
    .sets_p  (sets_p),
    .assoc_p (assoc_p)
  ) ctrl_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .cmd_v_i           (cmd_v_i),
    .cmd_pkt_i         (cmd_pkt),
    .cache_pkt_ready_i (cache_pkt_ready_i),
    .cache_data_v_i    (cache_data_v_i),
    .fifo_full_i       (fifo_full),
    .fifo_empty_i      (fifo_empty),
    .resp_ready_i      (resp_ready_i),
    .cmd_ready_o       (cmd_ready_o),
    .cache_pkt_o       (cache_pkt_o),
    .cache_pkt_v_o     (cache_pkt_v_o),
    .cache_data_yumi_o (cache_data_yumi_o),
    .fifo_push_o       (fifo_push),
    .fifo_pop_o        (fifo_pop),
    .resp_v_o          (resp_v_o)
  );

  // header at the FIFO head belongs to the word the cache returns next
  resp_header_fifo #(
    .outstanding_p (outstanding_p)
  ) fifo_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .push_i   (fifo_push),
    .header_i (cmd_header_i),
    .pop_i    (fifo_pop),
    .header_o (resp_header_o),
    .full_o   (fifo_full),
    .empty_o  (fifo_empty)
  );

  load_data_pack pack_i (
    .size_i (resp_header_o.size),
    .data_i (cache_data_i),
    .data_o (resp_data_o)
  );

endmodule

/* rtl/load_data_pack.sv */
// replicates the low bytes of returned cache data by response size
// the cache returns B/H/W/D data at the low end of the word
`timescale 1ns/100ps

module load_data_pack (
  input  cce_cache_pkg::msg_size_e size_i,
  input  cce_cache_pkg::data_t     data_i,
  output cce_cache_pkg::data_t     data_o
);

  always_comb
  begin
    case (size_i)
      cce_cache_pkg::size_1:
        data_o = {cce_cache_pkg::data_bytes_c{data_i[7:0]}};
      cce_cache_pkg::size_2:
        data_o = {(cce_cache_pkg::data_bytes_c / 2){data_i[15:0]}};
      cce_cache_pkg::size_4:
        data_o = {(cce_cache_pkg::data_bytes_c / 4){data_i[31:0]}};
      // full word passes unchanged
      default:
        data_o = data_i;
    endcase
  end

endmodule

/* rtl/resp_header_fifo.sv */
// in-order buffer of headers for commands still waiting on cache data
// push on full and pop on empty are not guarded here
`timescale 1ns/100ps

module resp_header_fifo #(
  parameter int outstanding_p = 2
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       push_i,
  input  cce_cache_pkg::mem_header_s header_i,
  input  logic                       pop_i,
  output cce_cache_pkg::mem_header_s header_o,
  output logic                       full_o,
  output logic                       empty_o
);

  localparam int ptr_width_lp = (outstanding_p > 1) ? $clog2(outstanding_p) : 1;
  localparam int cnt_width_lp = $clog2(outstanding_p + 1);

  cce_cache_pkg::mem_header_s mem_r [outstanding_p];
  logic [ptr_width_lp-1:0]    wr_ptr_r;
  logic [ptr_width_lp-1:0]    rd_ptr_r;
  logic [cnt_width_lp-1:0]    count_r;

  assign header_o = mem_r[rd_ptr_r];
  assign full_o   = (count_r == cnt_width_lp'(outstanding_p));
  assign empty_o  = (count_r == '0);

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem_r[wr_ptr_r] <= header_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      // pointers wrap at the entry count, which need not be a power of two
      if (push_i)
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(outstanding_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop_i)
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(outstanding_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      if (push_i && !pop_i)
        count_r <= count_r + 1'b1;
      else if (pop_i && !push_i)
        count_r <= count_r - 1'b1;
    end
  end

endmodule

/* rtl/cache_bridge_ctrl.sv */
// clears every cache tag after reset, then gates command, cache and response handshakes
// the clear ends only when every TAGST packet has been sent and its data word returned
`timescale 1ns/100ps

module cache_bridge_ctrl #(
  parameter int sets_p  = 16,
  parameter int assoc_p = 2
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      cmd_v_i,
  input  cce_cache_pkg::cache_pkt_s cmd_pkt_i,
  input  logic                      cache_pkt_ready_i,
  input  logic                      cache_data_v_i,
  input  logic                      fifo_full_i,
  input  logic                      fifo_empty_i,
  input  logic                      resp_ready_i,
  output logic                      cmd_ready_o,
  output cce_cache_pkg::cache_pkt_s cache_pkt_o,
  output logic                      cache_pkt_v_o,
  output logic                      cache_data_yumi_o,
  output logic                      fifo_push_o,
  output logic                      fifo_pop_o,
  output logic                      resp_v_o
);

  localparam int lines_lp     = sets_p * assoc_p;
  localparam int lg_lines_lp  = (lines_lp > 1) ? $clog2(lines_lp) : 1;
  localparam int cnt_width_lp = $clog2(lines_lp + 1);

  typedef enum logic [1:0] {st_reset, st_clear_tag, st_ready} state_e;

  state_e                  state_r;
  state_e                  state_n;
  logic [cnt_width_lp-1:0] sent_r;
  logic [cnt_width_lp-1:0] sent_n;
  logic [cnt_width_lp-1:0] received_r;
  logic [cnt_width_lp-1:0] received_n;

  always_comb
  begin
    state_n           = state_r;
    sent_n            = sent_r;
    received_n        = received_r;
    cache_pkt_o       = cmd_pkt_i;
    cache_pkt_v_o     = 1'b0;
    cmd_ready_o       = 1'b0;
    cache_data_yumi_o = 1'b0;
    fifo_push_o       = 1'b0;
    fifo_pop_o        = 1'b0;
    resp_v_o          = 1'b0;
    case (state_r)
      st_reset:
        state_n = st_clear_tag;
      st_clear_tag:
      begin
        // one TAGST per line, index goes into the set and way bits
        cache_pkt_o.opcode = cce_cache_pkg::op_tagst;
        cache_pkt_o.addr   = cce_cache_pkg::paddr_t'(sent_r[lg_lines_lp-1:0])
                             << cce_cache_pkg::block_offset_c;
        cache_pkt_o.data   = '0;
        cache_pkt_o.mask   = '0;
        cache_pkt_v_o      = (sent_r != cnt_width_lp'(lines_lp));
        // acknowledgements are swallowed, no response goes out
        cache_data_yumi_o  = cache_data_v_i;
        if (cache_pkt_v_o && cache_pkt_ready_i)
          sent_n = sent_r + 1'b1;
        if (cache_data_yumi_o)
          received_n = received_r + 1'b1;
        if ((sent_r == cnt_width_lp'(lines_lp)) && (received_r == cnt_width_lp'(lines_lp)))
          state_n = st_ready;
      end
      st_ready:
      begin
        cache_pkt_v_o     = cmd_v_i && !fifo_full_i;
        cmd_ready_o       = !fifo_full_i && cache_pkt_ready_i;
        fifo_push_o       = cmd_v_i && cmd_ready_o;
        resp_v_o          = !fifo_empty_i && cache_data_v_i;
        cache_data_yumi_o = resp_v_o && resp_ready_i;
        fifo_pop_o        = cache_data_yumi_o;
      end
      default:
        state_n = st_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r    <= st_reset;
      sent_r     <= '0;
      received_r <= '0;
    end
    else
    begin
      state_r    <= state_n;
      sent_r     <= sent_n;
      received_r <= received_n;
    end
  end

endmodule

/* rtl/cmd_opcode_decode.sv */
// maps a command header to a cache packet; lr and sc are not supported and become LB
// a tag flush takes its set and way from the low bits of the command data
`timescale 1ns/100ps

module cmd_opcode_decode #(
  parameter int sets_p  = 16,
  parameter int assoc_p = 2
) (
  input  cce_cache_pkg::mem_header_s cmd_header_i,
  input  cce_cache_pkg::data_t       cmd_data_i,
  input  cce_cache_pkg::data_t       store_data_i,
  input  cce_cache_pkg::mask_t       store_mask_i,
  output cce_cache_pkg::cache_pkt_s  cmd_pkt_o
);

  localparam int lines_lp    = sets_p * assoc_p;
  localparam int lg_lines_lp = (lines_lp > 1) ? $clog2(lines_lp) : 1;

  logic is_word;
  logic is_tagfl;

  assign is_word  = (cmd_header_i.size == cce_cache_pkg::size_4);
  // the tag flush address lies in configuration space
  assign is_tagfl = (cmd_header_i.addr == cce_cache_pkg::tagfl_addr_c);

  always_comb
  begin
    cmd_pkt_o.opcode = cce_cache_pkg::op_lb;
    cmd_pkt_o.addr   = cmd_header_i.addr;
    cmd_pkt_o.data   = store_data_i;
    cmd_pkt_o.mask   = store_mask_i;
    case (cmd_header_i.msg_type)
      cce_cache_pkg::msg_rd, cce_cache_pkg::msg_uc_rd:
        case (cmd_header_i.size)
          cce_cache_pkg::size_2: cmd_pkt_o.opcode = cce_cache_pkg::op_lh;
          cce_cache_pkg::size_4: cmd_pkt_o.opcode = cce_cache_pkg::op_lw;
          cce_cache_pkg::size_8: cmd_pkt_o.opcode = cce_cache_pkg::op_ld;
          default:               cmd_pkt_o.opcode = cce_cache_pkg::op_lb;
        endcase
      cce_cache_pkg::msg_wr, cce_cache_pkg::msg_uc_wr, cce_cache_pkg::msg_amo:
        case (cmd_header_i.size)
          cce_cache_pkg::size_1: cmd_pkt_o.opcode = cce_cache_pkg::op_sb;
          cce_cache_pkg::size_2: cmd_pkt_o.opcode = cce_cache_pkg::op_sh;
          cce_cache_pkg::size_4, cce_cache_pkg::size_8:
            // word or double form picked by size
            case (cmd_header_i.subop)
              cce_cache_pkg::subop_store:
                cmd_pkt_o.opcode = is_word ? cce_cache_pkg::op_sw : cce_cache_pkg::op_sd;
              cce_cache_pkg::subop_swap:
                cmd_pkt_o.opcode = is_word ? cce_cache_pkg::op_amoswap_w
                                           : cce_cache_pkg::op_amoswap_d;
              cce_cache_pkg::subop_add:
                cmd_pkt_o.opcode = is_word ? cce_cache_pkg::op_amoadd_w
                                           : cce_cache_pkg::op_amoadd_d;
              cce_cache_pkg::subop_xor:
                cmd_pkt_o.opcode = is_word ? cce_cache_pkg::op_amoxor_w
                                           : cce_cache_pkg::op_amoxor_d;
              cce_cache_pkg::subop_and:
                cmd_pkt_o.opcode = is_word ? cce_cache_pkg::op_amoand_w
                                           : cce_cache_pkg::op_amoand_d;
              cce_cache_pkg::subop_or:
                cmd_pkt_o.opcode = is_word ? cce_cache_pkg::op_amoor_w
                                           : cce_cache_pkg::op_amoor_d;
              cce_cache_pkg::subop_min:
                cmd_pkt_o.opcode = is_word ? cce_cache_pkg::op_amomin_w
                                           : cce_cache_pkg::op_amomin_d;
              cce_cache_pkg::subop_max:
                cmd_pkt_o.opcode = is_word ? cce_cache_pkg::op_amomax_w
                                           : cce_cache_pkg::op_amomax_d;
              cce_cache_pkg::subop_minu:
                cmd_pkt_o.opcode = is_word ? cce_cache_pkg::op_amominu_w
                                           : cce_cache_pkg::op_amominu_d;
              cce_cache_pkg::subop_maxu:
                cmd_pkt_o.opcode = is_word ? cce_cache_pkg::op_amomaxu_w
                                           : cce_cache_pkg::op_amomaxu_d;
              default:
                cmd_pkt_o.opcode = cce_cache_pkg::op_lb;
            endcase
          default: cmd_pkt_o.opcode = cce_cache_pkg::op_lb;
        endcase
      default:
        cmd_pkt_o.opcode = cce_cache_pkg::op_lb;
    endcase
    if (is_tagfl)
    begin
      cmd_pkt_o.opcode = cce_cache_pkg::op_tagfl;
      cmd_pkt_o.addr   = cce_cache_pkg::paddr_t'(cmd_data_i[lg_lines_lp-1:0])
                         << cce_cache_pkg::block_offset_c;
      cmd_pkt_o.data   = '0;
      cmd_pkt_o.mask   = '0;
    end
  end

endmodule

/* rtl/store_data_align.sv */
// replicates store data across the word and builds the byte mask
// sizes above 8 bytes are not supported and are treated as 8
`timescale 1ns/100ps

module store_data_align (
  input  cce_cache_pkg::msg_size_e size_i,
  input  cce_cache_pkg::paddr_t    addr_i,
  input  cce_cache_pkg::data_t     data_i,
  output cce_cache_pkg::data_t     data_o,
  output cce_cache_pkg::mask_t     mask_o
);

  always_comb
  begin
    case (size_i)
      cce_cache_pkg::size_1:
      begin
        data_o = {cce_cache_pkg::data_bytes_c{data_i[7:0]}};
        mask_o = cce_cache_pkg::mask_t'(8'h01) << addr_i[2:0];
      end
      cce_cache_pkg::size_2:
      begin
        data_o = {(cce_cache_pkg::data_bytes_c / 2){data_i[15:0]}};
        // halfword slice picked by addr bits 2:1
        mask_o = cce_cache_pkg::mask_t'(8'h03) << {addr_i[2:1], 1'b0};
      end
      cce_cache_pkg::size_4:
      begin
        data_o = {(cce_cache_pkg::data_bytes_c / 4){data_i[31:0]}};
        mask_o = cce_cache_pkg::mask_t'(8'h0f) << {addr_i[2], 2'b00};
      end
      default:
      begin
        data_o = data_i;
        mask_o = '1;
      end
    endcase
  end

endmodule

/* rtl/cce_cache_pkg.sv */
// shared widths, encodings and packet layouts for the command to cache bridge
// data width is fixed at 64 bits because the opcode and mask tables assume it
package cce_cache_pkg;

  localparam int data_width_c  = 64;
  localparam int data_bytes_c  = data_width_c / 8;
  localparam int paddr_width_c = 32;

  typedef logic [data_width_c-1:0]  data_t;
  typedef logic [data_bytes_c-1:0]  mask_t;
  typedef logic [paddr_width_c-1:0] paddr_t;

  typedef enum logic [2:0] {msg_rd, msg_uc_rd, msg_wr, msg_uc_wr, msg_amo} msg_type_e;

  // log2 of the byte count
  typedef enum logic [2:0] {size_1, size_2, size_4, size_8} msg_size_e;

  typedef enum logic [3:0] {
    subop_store, subop_swap, subop_add, subop_xor, subop_and, subop_or,
    subop_min, subop_max, subop_minu, subop_maxu, subop_lr, subop_sc
  } subop_e;

  typedef enum logic [5:0] {
    op_lb = 6'h00, op_lh = 6'h01, op_lw = 6'h02, op_ld = 6'h03,
    op_sb = 6'h08, op_sh = 6'h09, op_sw = 6'h0a, op_sd = 6'h0b,
    op_tagst = 6'h10, op_tagfl = 6'h11,
    op_amoswap_w = 6'h20, op_amoswap_d = 6'h21, op_amoadd_w = 6'h22, op_amoadd_d = 6'h23,
    op_amoxor_w = 6'h24, op_amoxor_d = 6'h25, op_amoand_w = 6'h26, op_amoand_d = 6'h27,
    op_amoor_w = 6'h28, op_amoor_d = 6'h29, op_amomin_w = 6'h2a, op_amomin_d = 6'h2b,
    op_amomax_w = 6'h2c, op_amomax_d = 6'h2d, op_amominu_w = 6'h2e, op_amominu_d = 6'h2f,
    op_amomaxu_w = 6'h30, op_amomaxu_d = 6'h31
  } cache_opcode_e;

  // command and response header
  typedef struct packed {
    msg_type_e msg_type;
    subop_e    subop;
    msg_size_e size;
    paddr_t    addr;
  } mem_header_s;

  typedef struct packed {
    cache_opcode_e opcode;
    paddr_t        addr;
    data_t         data;
    mask_t         mask;
  } cache_pkt_s;

  // below dram_base_c is configuration space
  localparam paddr_t dram_base_c    = 32'h8000_0000;
  localparam paddr_t tagfl_addr_c   = 32'h0020_0000;
  localparam int     block_offset_c = 6;

endpackage
